/* load_issue_top.f */
verilog/load_op_pkg.sv
verilog/issue_pkg.sv
verilog/dispatch_receiver.sv
verilog/load_issue_bank.sv
verilog/issue_sender.sv
verilog/load_issue_top.sv
verif/load_issue_checker.sv
verif/load_issue_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failure.
verilator --binary --timing --top-module load_issue_tb -f load_issue_top.f \
    -o sim_load_issue > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_load_issue > sim.log 2>&1 \
    || { echo "simulation run failed, see sim.log"; exit 1; }
! grep -q "Simulation failed" sim.log \
    && grep -q "Simulation completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }

/* verif/load_issue_checker.sv */
`timescale 1ns/1ps

module load_issue_checker #(
    parameter int depth      = 8,
    parameter int preg_width = 6,
    parameter int wb_ports   = 2
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                disp_ack,
    input  load_op_pkg::mem_op_e                disp_op,
    input  logic [preg_width-1:0]               disp_rs1,
    input  logic                                disp_rs1_ready,
    input  logic [11:0]                         disp_imm,
    input  logic [preg_width-1:0]               disp_rd,
    input  logic [5:0]                          disp_rob_idx,
    input  logic [wb_ports-1:0]                 wb_en,
    input  logic [wb_ports-1:0][preg_width-1:0] wb_preg,
    input  logic                                load_req,
    input  load_op_pkg::mem_op_e                load_op,
    input  logic [preg_width-1:0]               load_rs1,
    input  logic [11:0]                         load_imm,
    input  logic [preg_width-1:0]               load_rd,
    input  logic [5:0]                          load_rob_idx,
    input  logic [$clog2(depth)-1:0]            load_idx,
    input  logic                                reply_en,
    input  logic [$clog2(depth)-1:0]            reply_idx,
    input  logic                                reply_ok,
    input  logic                                redirect,
    input  logic [5:0]                          redirect_rob_idx,
    input  logic                                done,
    output int                                  value_errors,
    output int                                  other_errors
);

    logic in_bank [64];
    logic woken [64];
    logic issued [64];
    logic [2:0] exp_op [64];
    logic [preg_width-1:0] exp_rs1 [64];
    logic [11:0] exp_imm [64];
    logic [preg_width-1:0] exp_rd [64];
    logic [$clog2(depth)-1:0] exp_slot [64];
    logic [5:0] idx_rob [depth];
    logic [depth-1:0] slot_used;
    logic [depth-1:0] freed_now;
    logic [depth-1:0] freed_last;
    logic [5:0] r;
    logic ack_q;
    logic req_q;
    logic done_q;
    logic [wb_ports-1:0] wb_en_q;
    logic [wb_ports-1:0][preg_width-1:0] wb_preg_q;
    int bank_count;
    int slot;

    task automatic compare_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < 64; k++) begin
                in_bank[k] = 1'b0;
                woken[k]   = 1'b0;
                issued[k]  = 1'b0;
            end
            {ack_q, req_q, done_q, wb_en_q, wb_preg_q} = '0;
            slot_used    = '0;
            freed_now    = '0;
            freed_last   = '0;
            bank_count   = 0;
            value_errors = 0;
            other_errors = 0;
        end else begin
            freed_now = '0;
            // the ack rose on the previous edge, and the fields are still held.
            if (disp_ack && !ack_q) begin
                if (bank_count == depth) begin
                    other_errors++;
                    $display("dispatch of rob 0x%0h accepted while the bank was full",
                             disp_rob_idx);
                end
                r = disp_rob_idx;
                // the entry was written before the frees of that same edge took effect.
                slot = 0;
                for (int s = depth - 1; s >= 0; s--) begin
                    if (!slot_used[s] && !freed_last[s]) begin
                        slot = s;
                    end
                end
                slot_used[slot] = 1'b1;
                exp_slot[r]     = slot[$clog2(depth)-1:0];
                idx_rob[slot]   = r;
                in_bank[r]  = 1'b1;
                issued[r]   = 1'b0;
                woken[r]    = disp_rs1_ready;
                exp_op[r]   = disp_op;
                exp_rs1[r]  = disp_rs1;
                exp_imm[r]  = disp_imm;
                exp_rd[r]   = disp_rd;
                for (int j = 0; j < wb_ports; j++) begin
                    if (wb_en_q[j] && wb_preg_q[j] == disp_rs1) woken[r] = 1'b1;
                end
                bank_count++;
            end
            for (int k = 0; k < 64; k++) begin
                for (int j = 0; j < wb_ports; j++) begin
                    if (in_bank[k] && wb_en[j] && wb_preg[j] == exp_rs1[k]) woken[k] = 1'b1;
                end
            end
            if (load_req && !req_q) begin
                r = load_rob_idx;
                if (!in_bank[r]) begin
                    other_errors++;
                    $display("rob 0x%0h issued although it is not held in the bank", r);
                end else if (!woken[r]) begin
                    other_errors++;
                    $display("rob 0x%0h issued before its base register was written", r);
                end else if (issued[r]) begin
                    other_errors++;
                    $display("rob 0x%0h issued again while it still waited for a reply", r);
                end
                issued[r] = 1'b1;
                compare_value("load_op", 32'(load_op), 32'(exp_op[r]));
                compare_value("load_rs1", 32'(load_rs1), 32'(exp_rs1[r]));
                compare_value("load_imm", 32'(load_imm), 32'(exp_imm[r]));
                compare_value("load_rd", 32'(load_rd), 32'(exp_rd[r]));
                compare_value("load_idx", 32'(load_idx), 32'(exp_slot[r]));
            end
            if (reply_en && in_bank[idx_rob[reply_idx]]) begin
                if (reply_ok) begin
                    in_bank[idx_rob[reply_idx]] = 1'b0;
                    slot_used[reply_idx] = 1'b0;
                    freed_now[reply_idx] = 1'b1;
                    bank_count--;
                end else begin
                    issued[idx_rob[reply_idx]] = 1'b0;
                end
            end
            if (redirect) begin
                for (int k = 0; k < 64; k++) begin
                    if (in_bank[k] && issue_pkg::younger(6'(k), redirect_rob_idx)) begin
                        in_bank[k] = 1'b0;
                        slot_used[exp_slot[k]] = 1'b0;
                        freed_now[exp_slot[k]] = 1'b1;
                        bank_count--;
                    end
                end
            end
            // anything still held and woken at the end never got its ok reply.
            if (done && !done_q) begin
                for (int k = 0; k < 64; k++) begin
                    if (in_bank[k] && woken[k]) begin
                        other_errors++;
                        $display("rob 0x%0h was woken but never completed", k);
                    end
                end
            end
            freed_last = freed_now;
            ack_q      = disp_ack;
            req_q      = load_req;
            done_q     = done;
            wb_en_q    = wb_en;
            wb_preg_q  = wb_preg;
        end
    end

endmodule

/* verif/load_issue_tb.sv */
`timescale 1ns/1ps

module load_issue_tb;

    localparam int depth      = 8;
    localparam int preg_width = 6;
    localparam int wb_ports   = 2;
    localparam int n_rows     = 19;

    typedef struct packed {
        load_op_pkg::mem_op_e op;
        logic [5:0]           rs1;
        logic                 rdy;
        logic [5:0]           rd;
        logic [5:0]           rob;
        int                   wb_off;
        logic                 replay;
        logic                 drain;
        logic                 redir;
        logic [5:0]           redir_rob;
    } row_t;

    logic clk;
    logic rst_n;
    logic disp_req;
    load_op_pkg::mem_op_e disp_op;
    logic [5:0] disp_rs1;
    logic disp_rs1_ready;
    logic [11:0] disp_imm;
    logic [5:0] disp_rd;
    logic [5:0] disp_rob_idx;
    logic disp_ack;
    logic [wb_ports-1:0] wb_en;
    logic [wb_ports-1:0][preg_width-1:0] wb_preg;
    logic load_req;
    load_op_pkg::mem_op_e load_op;
    logic [5:0] load_rs1;
    logic [11:0] load_imm;
    logic [5:0] load_rd;
    logic [5:0] load_rob_idx;
    logic [2:0] load_idx;
    logic load_ack;
    logic reply_en;
    logic [2:0] reply_idx;
    logic reply_ok;
    logic redirect;
    logic [5:0] redirect_rob_idx;
    logic done;
    int value_errors;
    int other_errors;

    row_t rows [n_rows];
    logic [31:0] lfsr_state;
    logic replay_wanted [64];
    logic replayed [64];

    load_issue_top #(.depth(depth), .preg_width(preg_width), .wb_ports(wb_ports)) UUT (.*);

    load_issue_checker #(
        .depth(depth), .preg_width(preg_width), .wb_ports(wb_ports)
    ) u_checker (.*);

    function automatic row_t make_row(load_op_pkg::mem_op_e op, logic [5:0] rs1, logic rdy,
            logic [5:0] rob, int wb_off, logic replay, logic drain, logic redir,
            logic [5:0] redir_rob);
        row_t r;
        r = '{op, rs1, rdy, rob ^ 6'h15, rob, wb_off, replay, drain, redir, redir_rob};
        return r;
    endfunction

    // galois lfsr, one step per bit handed out.
    function automatic logic [31:0] take_bits(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    task automatic wait_quiet();
        int quiet;
        quiet = 0;
        while (quiet < 12) begin
            @(negedge clk);
            quiet = (load_req || load_ack || reply_en) ? 0 : quiet + 1;
        end
    endtask

    task automatic launch_wb(input logic [5:0] preg, input int off);
        fork
            begin
                repeat (off) @(negedge clk);
                wb_en[preg[0]]   = 1'b1;
                wb_preg[preg[0]] = preg;
                @(negedge clk);
                wb_en[preg[0]] = 1'b0;
            end
        join_none
    endtask

    task automatic apply_row(input row_t r);
        logic [31:0] imm_bits;
        if (r.drain) wait_quiet();
        imm_bits = take_bits(12);
        @(negedge clk);
        disp_op        = r.op;
        disp_rs1       = r.rs1;
        disp_rs1_ready = r.rdy;
        disp_imm       = imm_bits[11:0];
        disp_rd        = r.rd;
        disp_rob_idx   = r.rob;
        replay_wanted[r.rob] = r.replay;
        replayed[r.rob]      = 1'b0;
        if (r.wb_off >= 0) launch_wb(r.rs1, r.wb_off);
        disp_req = 1'b1;
        do @(negedge clk); while (!disp_ack);
        disp_req = 1'b0;
        do @(negedge clk); while (disp_ack);
        if (r.redir) begin
            wait_quiet();
            redirect         = 1'b1;
            redirect_rob_idx = r.redir_rob;
            @(negedge clk);
            redirect = 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // load unit: ack after a short random delay, then reply.
    initial begin
        logic [5:0] rob;
        logic [2:0] idx;
        logic [31:0] delay;
        forever begin
            @(negedge clk);
            if (load_req && !load_ack) begin
                rob = load_rob_idx;
                idx = load_idx;
                delay = take_bits(2);
                repeat (delay) @(negedge clk);
                load_ack = 1'b1;
                do @(negedge clk); while (load_req);
                load_ack  = 1'b0;
                reply_idx = idx;
                reply_ok  = !(replay_wanted[rob] && !replayed[rob]);
                replayed[rob] = 1'b1;
                reply_en  = 1'b1;
                @(negedge clk);
                reply_en = 1'b0;
            end
        end
    end

    initial begin
        repeat (n_rows * 40 + 8) @(posedge clk);
        $display("watchdog expired after %0d cycles with the run unfinished", n_rows * 40 + 8);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        disp_req = 1'b0;
        disp_op = load_op_pkg::mem_lb;
        disp_rs1 = '0;
        disp_rs1_ready = 1'b0;
        disp_imm = '0;
        disp_rd = '0;
        disp_rob_idx = '0;
        wb_en = '0;
        wb_preg = '0;
        load_ack = 1'b0;
        reply_en = 1'b0;
        reply_idx = '0;
        reply_ok = 1'b0;
        redirect = 1'b0;
        redirect_rob_idx = '0;
        done = 1'b0;
        lfsr_state = 32'd84399;
        for (int i = 0; i < 64; i++) begin
            replay_wanted[i] = 1'b0;
            replayed[i]      = 1'b0;
        end
        rows[0]  = make_row(load_op_pkg::mem_lw, 1, 1, 0, -1, 0, 0, 0, 0);
        rows[1]  = make_row(load_op_pkg::mem_lb, 2, 1, 1, -1, 1, 0, 0, 0);
        rows[2]  = make_row(load_op_pkg::mem_lh, 3, 0, 2, 6, 0, 0, 0, 0);
        rows[3]  = make_row(load_op_pkg::mem_lbu, 4, 0, 3, 3, 1, 0, 0, 0);
        rows[4]  = make_row(load_op_pkg::mem_lhu, 5, 1, 4, -1, 0, 0, 0, 0);
        // rows 5 to 12 fill the bank on one base register, woken late by row 12.
        rows[5]  = make_row(load_op_pkg::mem_lw, 9, 0, 5, -1, 0, 1, 0, 0);
        rows[6]  = make_row(load_op_pkg::mem_lb, 9, 0, 6, -1, 0, 0, 0, 0);
        rows[7]  = make_row(load_op_pkg::mem_lh, 9, 0, 7, -1, 1, 0, 0, 0);
        rows[8]  = make_row(load_op_pkg::mem_lbu, 9, 0, 8, -1, 0, 0, 0, 0);
        rows[9]  = make_row(load_op_pkg::mem_lhu, 9, 0, 9, -1, 0, 0, 0, 0);
        rows[10] = make_row(load_op_pkg::mem_lw, 9, 0, 10, -1, 0, 0, 0, 0);
        rows[11] = make_row(load_op_pkg::mem_lb, 9, 0, 11, -1, 0, 0, 0, 0);
        rows[12] = make_row(load_op_pkg::mem_lw, 9, 0, 12, 30, 0, 0, 0, 0);
        rows[13] = make_row(load_op_pkg::mem_lh, 10, 1, 13, -1, 1, 0, 0, 0);
        rows[14] = make_row(load_op_pkg::mem_lb, 11, 0, 14, -1, 0, 0, 0, 0);
        rows[15] = make_row(load_op_pkg::mem_lbu, 12, 0, 15, -1, 0, 0, 1, 14);
        // row 16 reuses rob 14 and wakes the base register of the flushed row 15.
        rows[16] = make_row(load_op_pkg::mem_lw, 12, 0, 14, 4, 0, 0, 0, 0);
        rows[17] = make_row(load_op_pkg::mem_lhu, 14, 1, 'h20, -1, 1, 0, 0, 0);
        rows[18] = make_row(load_op_pkg::mem_lw, 15, 0, 'h21, 4, 0, 0, 0, 0);
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            apply_row(rows[i]);
        end
        wait_quiet();
        done = 1'b1;
        repeat (2) @(negedge clk);
        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog/dispatch_receiver.sv */
`timescale 1ns/1ps

module dispatch_receiver #(
    parameter int preg_width = 6
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   disp_req,
    input  load_op_pkg::mem_op_e                   disp_op,
    input  logic [preg_width-1:0]                  disp_rs1,
    input  logic                                   disp_rs1_ready,
    input  logic [load_op_pkg::imm_width-1:0]      disp_imm,
    input  logic [preg_width-1:0]                  disp_rd,
    input  logic [load_op_pkg::rob_idx_width:0]    disp_rob_idx,
    input  logic                                   bank_full,
    output logic                                   disp_ack,
    output logic                                   alloc_en,
    output load_op_pkg::mem_op_e                   alloc_op,
    output logic [preg_width-1:0]                  alloc_rs1,
    output logic                                   alloc_rs1_ready,
    output logic [load_op_pkg::imm_width-1:0]      alloc_imm,
    output logic [preg_width-1:0]                  alloc_rd,
    output logic [load_op_pkg::rob_idx_width:0]    alloc_rob_idx
);

    issue_pkg::hs_state_e state;
    logic                 can_take;

    // a request can only be taken before its ack has gone out.
    // hs_req_high is the stall state while the bank has no room.
    assign can_take = (state == issue_pkg::hs_idle) || (state == issue_pkg::hs_req_high);

    // the strobe lands on the same edge that raises disp_ack.
    assign alloc_en = can_take && disp_req && !bank_full;

    // dispatch holds its fields stable until it sees the ack,
    // so the bank writes them straight from the request lines.
    assign alloc_op        = disp_op;
    assign alloc_rs1       = disp_rs1;
    assign alloc_rs1_ready = disp_rs1_ready;
    assign alloc_imm       = disp_imm;
    assign alloc_rd        = disp_rd;
    assign alloc_rob_idx   = disp_rob_idx;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= issue_pkg::hs_idle;
            disp_ack <= 1'b0;
        end else begin
            case (state)
                issue_pkg::hs_idle, issue_pkg::hs_req_high: begin
                    if (alloc_en) begin
                        disp_ack <= 1'b1;
                        state    <= issue_pkg::hs_wait_low;
                    end else if (disp_req) begin
                        // bank is full, hold the ack back.
                        state <= issue_pkg::hs_req_high;
                    end
                end
                issue_pkg::hs_wait_low: begin
                    // one entry per transfer, so nothing more until req drops.
                    if (!disp_req) begin
                        disp_ack <= 1'b0;
                        state    <= issue_pkg::hs_idle;
                    end
                end
                default: begin
                    disp_ack <= 1'b0;
                    state    <= issue_pkg::hs_idle;
                end
            endcase
        end
    end

endmodule

/* verilog/issue_pkg.sv */
package issue_pkg;

    // states shared by both four-phase handshakes.
    // hs_req_high means a request is being served and
    // hs_wait_low means the ack is out and the peer must drop its side.
    typedef enum logic [1:0] {
        hs_idle,
        hs_req_high,
        hs_wait_low
    } hs_state_e;

    // age compare between a stored rob index and a redirect point.
    // the direction bits flip each time the rob wraps, so when they differ
    // the plain index compare has to be inverted.
    // the redirect point itself is refetched, so it counts as younger.
    function automatic logic younger(
        input logic [load_op_pkg::rob_idx_width:0] stored_idx,
        input logic [load_op_pkg::rob_idx_width:0] redirect_idx
    );
        logic dir_diff;
        logic idx_gt;
        logic older;
        dir_diff = stored_idx[load_op_pkg::rob_idx_width]
                 ^ redirect_idx[load_op_pkg::rob_idx_width];
        idx_gt = redirect_idx[load_op_pkg::rob_idx_width-1:0]
               > stored_idx[load_op_pkg::rob_idx_width-1:0];
        older = dir_diff ^ idx_gt;
        return !older;
    endfunction

endpackage

/* verilog/issue_sender.sv */
`timescale 1ns/1ps

module issue_sender #(
    parameter int depth      = 8,
    parameter int preg_width = 6
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   pick_valid,
    input  logic [$clog2(depth)-1:0]               pick_idx,
    input  load_op_pkg::mem_op_e                   pick_op,
    input  logic [preg_width-1:0]                  pick_rs1,
    input  logic [load_op_pkg::imm_width-1:0]      pick_imm,
    input  logic [preg_width-1:0]                  pick_rd,
    input  logic [load_op_pkg::rob_idx_width:0]    pick_rob_idx,
    input  logic                                   load_ack,
    output logic                                   pick_take,
    output logic                                   load_req,
    output load_op_pkg::mem_op_e                   load_op,
    output logic [preg_width-1:0]                  load_rs1,
    output logic [load_op_pkg::imm_width-1:0]      load_imm,
    output logic [preg_width-1:0]                  load_rd,
    output logic [load_op_pkg::rob_idx_width:0]    load_rob_idx,
    output logic [$clog2(depth)-1:0]               load_idx
);

    issue_pkg::hs_state_e state;

    // only an idle sender has room for another load.
    assign pick_take = (state == issue_pkg::hs_idle) && pick_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= issue_pkg::hs_idle;
            load_req <= 1'b0;
        end else begin
            case (state)
                issue_pkg::hs_idle: begin
                    if (pick_take) begin
                        load_req <= 1'b1;
                        state    <= issue_pkg::hs_req_high;
                    end
                end
                issue_pkg::hs_req_high: begin
                    if (load_ack) begin
                        load_req <= 1'b0;
                        state    <= issue_pkg::hs_wait_low;
                    end
                end
                issue_pkg::hs_wait_low: begin
                    // the load unit still holds ack high, wait it out.
                    if (!load_ack) begin
                        state <= issue_pkg::hs_idle;
                    end
                end
                default: begin
                    load_req <= 1'b0;
                    state    <= issue_pkg::hs_idle;
                end
            endcase
        end
    end

    // payload stays put from the take until the next take.
    always_ff @(posedge clk) begin
        if (pick_take) begin
            load_op      <= pick_op;
            load_rs1     <= pick_rs1;
            load_imm     <= pick_imm;
            load_rd      <= pick_rd;
            load_rob_idx <= pick_rob_idx;
            load_idx     <= pick_idx;
        end
    end

endmodule

/* verilog/load_issue_bank.sv */
`timescale 1ns/1ps

module load_issue_bank #(
    parameter int depth      = 8,
    parameter int preg_width = 6,
    parameter int wb_ports   = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   alloc_en,
    input  load_op_pkg::mem_op_e                   alloc_op,
    input  logic [preg_width-1:0]                  alloc_rs1,
    input  logic                                   alloc_rs1_ready,
    input  logic [load_op_pkg::imm_width-1:0]      alloc_imm,
    input  logic [preg_width-1:0]                  alloc_rd,
    input  logic [load_op_pkg::rob_idx_width:0]    alloc_rob_idx,
    input  logic [wb_ports-1:0]                    wb_en,
    input  logic [wb_ports-1:0][preg_width-1:0]    wb_preg,
    input  logic                                   pick_take,
    input  logic                                   reply_en,
    input  logic [$clog2(depth)-1:0]               reply_idx,
    input  logic                                   reply_ok,
    input  logic                                   redirect,
    input  logic [load_op_pkg::rob_idx_width:0]    redirect_rob_idx,
    output logic                                   bank_full,
    output logic                                   pick_valid,
    output logic [$clog2(depth)-1:0]               pick_idx,
    output load_op_pkg::mem_op_e                   pick_op,
    output logic [preg_width-1:0]                  pick_rs1,
    output logic [load_op_pkg::imm_width-1:0]      pick_imm,
    output logic [preg_width-1:0]                  pick_rd,
    output logic [load_op_pkg::rob_idx_width:0]    pick_rob_idx
);

    localparam int idx_width = $clog2(depth);

    logic [depth-1:0] valid;
    logic [depth-1:0] rs1_rdy;
    logic [depth-1:0] issued;
    logic [depth-1:0] ready;
    logic [depth-1:0] wake;
    logic [depth-1:0] flush;

    load_op_pkg::mem_op_e                  op_q  [depth];
    logic [preg_width-1:0]                 rs1_q [depth];
    logic [load_op_pkg::imm_width-1:0]     imm_q [depth];
    logic [preg_width-1:0]                 rd_q  [depth];
    logic [load_op_pkg::rob_idx_width:0]   rob_q [depth];

    logic [idx_width-1:0] free_idx;
    logic                 alloc_wake;

    assign bank_full = &valid;
    assign ready     = valid & rs1_rdy & ~issued;

    // lowest free slot, found by scanning down so the last hit wins.
    always_comb begin
        free_idx = '0;
        for (int i = depth - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = idx_width'(i);
            end
        end
    end

    // fixed priority pick, entry 0 first.
    always_comb begin
        pick_idx = '0;
        for (int i = depth - 1; i >= 0; i--) begin
            if (ready[i]) begin
                pick_idx = idx_width'(i);
            end
        end
    end

    assign pick_valid   = |ready;
    assign pick_op      = op_q[pick_idx];
    assign pick_rs1     = rs1_q[pick_idx];
    assign pick_imm     = imm_q[pick_idx];
    assign pick_rd      = rd_q[pick_idx];
    assign pick_rob_idx = rob_q[pick_idx];

    // writeback match for stored entries and for the one being written.
    always_comb begin
        wake       = '0;
        alloc_wake = 1'b0;
        for (int i = 0; i < depth; i++) begin
            for (int j = 0; j < wb_ports; j++) begin
                if (wb_en[j] && valid[i] && (wb_preg[j] == rs1_q[i])) begin
                    wake[i] = 1'b1;
                end
            end
        end
        for (int j = 0; j < wb_ports; j++) begin
            if (wb_en[j] && (wb_preg[j] == alloc_rs1)) begin
                alloc_wake = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < depth; i++) begin
            flush[i] = valid[i] && issue_pkg::younger(rob_q[i], redirect_rob_idx);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid   <= '0;
            rs1_rdy <= '0;
            issued  <= '0;
        end else begin
            rs1_rdy <= rs1_rdy | wake;
            if (pick_take) begin
                issued[pick_idx] <= 1'b1;
            end
            if (redirect) begin
                valid <= valid & ~flush;
            end else begin
                if (alloc_en) begin
                    valid[free_idx]   <= 1'b1;
                    rs1_rdy[free_idx] <= alloc_rs1_ready | alloc_wake;
                    issued[free_idx]  <= 1'b0;
                end
                // a reply for an entry that is already gone is dropped.
                if (reply_en && valid[reply_idx]) begin
                    if (reply_ok) begin
                        valid[reply_idx] <= 1'b0;
                    end else begin
                        issued[reply_idx] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            op_q[free_idx]  <= alloc_op;
            rs1_q[free_idx] <= alloc_rs1;
            imm_q[free_idx] <= alloc_imm;
            rd_q[free_idx]  <= alloc_rd;
            rob_q[free_idx] <= alloc_rob_idx;
        end
    end

endmodule

/* verilog/load_issue_top.sv */
`timescale 1ns/1ps

module load_issue_top #(
    parameter int depth      = 8,
    parameter int preg_width = 6,
    parameter int wb_ports   = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   disp_req,
    input  load_op_pkg::mem_op_e                   disp_op,
    input  logic [preg_width-1:0]                  disp_rs1,
    input  logic                                   disp_rs1_ready,
    input  logic [load_op_pkg::imm_width-1:0]      disp_imm,
    input  logic [preg_width-1:0]                  disp_rd,
    input  logic [load_op_pkg::rob_idx_width:0]    disp_rob_idx,
    output logic                                   disp_ack,
    input  logic [wb_ports-1:0]                    wb_en,
    input  logic [wb_ports-1:0][preg_width-1:0]    wb_preg,
    output logic                                   load_req,
    output load_op_pkg::mem_op_e                   load_op,
    output logic [preg_width-1:0]                  load_rs1,
    output logic [load_op_pkg::imm_width-1:0]      load_imm,
    output logic [preg_width-1:0]                  load_rd,
    output logic [load_op_pkg::rob_idx_width:0]    load_rob_idx,
    output logic [$clog2(depth)-1:0]               load_idx,
    input  logic                                   load_ack,
    input  logic                                   reply_en,
    input  logic [$clog2(depth)-1:0]               reply_idx,
    input  logic                                   reply_ok,
    input  logic                                   redirect,
    input  logic [load_op_pkg::rob_idx_width:0]    redirect_rob_idx
);

    logic                                 alloc_en;
    load_op_pkg::mem_op_e                 alloc_op;
    logic [preg_width-1:0]                alloc_rs1;
    logic                                 alloc_rs1_ready;
    logic [load_op_pkg::imm_width-1:0]    alloc_imm;
    logic [preg_width-1:0]                alloc_rd;
    logic [load_op_pkg::rob_idx_width:0]  alloc_rob_idx;
    logic                                 bank_full;

    logic                                 pick_valid;
    logic                                 pick_take;
    logic [$clog2(depth)-1:0]             pick_idx;
    load_op_pkg::mem_op_e                 pick_op;
    logic [preg_width-1:0]                pick_rs1;
    logic [load_op_pkg::imm_width-1:0]    pick_imm;
    logic [preg_width-1:0]                pick_rd;
    logic [load_op_pkg::rob_idx_width:0]  pick_rob_idx;

    dispatch_receiver #(
        .preg_width (preg_width)
    ) u_receiver (
        .*
    );

    load_issue_bank #(
        .depth      (depth),
        .preg_width (preg_width),
        .wb_ports   (wb_ports)
    ) u_bank (
        .*
    );

    issue_sender #(
        .depth      (depth),
        .preg_width (preg_width)
    ) u_sender (
        .*
    );

endmodule

/* verilog/load_op_pkg.sv */
package load_op_pkg;

    // width of the reorder-buffer index below the wrap bit.
    // every rob index in the back end carries one extra direction bit on top,
    // so a full rob index is rob_idx_width + 1 bits wide.
    parameter int rob_idx_width = 5;

    // signed offset added to the base register by the load unit.
    parameter int imm_width = 12;

    // width of the opcode field below.
    parameter int mem_op_width = 3;

    // load opcodes.
    // the unsigned forms only differ from the signed ones in how
    // the load unit extends the returned data.
    typedef enum logic [mem_op_width-1:0] {
        // byte, sign extended.
        mem_lb,
        // halfword, sign extended.
        mem_lh,
        // word.
        mem_lw,
        // byte, zero extended.
        mem_lbu,
        // halfword, zero extended.
        mem_lhu
    } mem_op_e;

    // the issue stage never decodes the opcode.
    // it only carries it from dispatch to the load unit, so
    // the encodings above may change without touching the bank.

endpackage
